// File: tb.f
+incdir+.
aluPkg.sv
carrySelectAdder.sv
compareUnit.sv
resultSelect.sv
aluOutputStage.sv
exAlu.sv
aluChk.sv
tbExAlu.sv

// File: aluModel.svh
// reference model of the ALU, value and new T worked out from the operation rules
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// low w bits of a word, w is 64 with qword and 32 without
function automatic logic [63:0] lowBits(input logic [63:0] v, input logic qword);
	return qword ? v : {32'b0, v[31:0]};
endfunction

// the w-bit value read as a signed number
function automatic logic signed [64:0] asSigned(input logic [63:0] v, input logic qword);
	return qword ? {v[63], v} : {{33{v[31]}}, v[31:0]};
endfunction

// {new T, result} for one operation
function automatic logic [64:0] modelAlu(
	input logic [63:0] rs,
	input logic [63:0] rt,
	input aluPkg::aluOp op,
	input logic qword,
	input logic zeroExt,
	input logic tIn
);
	logic [63:0] a;
	logic [63:0] b;
	logic [64:0] wide;
	logic [63:0] value;
	logic t;
	int w;
	a = lowBits(rs, qword);
	b = lowBits(rt, qword);
	w = qword ? 64 : 32;
	value = '0;
	t = tIn;
	case (op)
		aluPkg::ADD: value = a + b;
		aluPkg::SUB: value = a - b;
		aluPkg::ADC: begin
			wide = {1'b0, a} + {1'b0, b} + tIn;
			value = wide[63:0];
			t = wide[w];
		end
		aluPkg::SBB: begin
			value = a - b - tIn;
			wide = {1'b0, a} + {1'b0, lowBits(~b, qword)} + !tIn;
			t = !wide[w];
		end
		aluPkg::TST:   t = (a & b) == '0;
		aluPkg::AND:   value = rs & rt;
		aluPkg::OR:    value = rs | rt;
		aluPkg::XOR:   value = rs ^ rt;
		aluPkg::CMPEQ: t = a == b;
		aluPkg::CMPNE: t = a != b;
		aluPkg::CMPHS: t = a >= b;
		aluPkg::CMPHI: t = a > b;
		aluPkg::CMPGE: t = asSigned(a, qword) >= asSigned(b, qword);
		aluPkg::CMPGT: t = asSigned(a, qword) > asSigned(b, qword);
		aluPkg::CSELT: value = tIn ? rs : rt;
		// reserved NOR keeps zero and T
		default: value = '0;
	endcase
	if (!qword) begin
		value = zeroExt ? {32'b0, value[31:0]} : {{32{value[31]}}, value[31:0]};
	end
	return {t, value};
endfunction

`endif

// File: tbExAlu.sv
// testbench for exAlu, xorshift stimulus, model queue and handshake timing check
module tbExAlu;

	localparam int numOps = 3000;
	// far more cycles than the run needs even under heavy back-pressure
	localparam int timeoutCycles = numOps * 20;

	logic clock;
	logic rstN;
	logic inValid;
	logic inReady;
	aluPkg::aluWord rs;
	aluPkg::aluWord rt;
	aluPkg::aluOp op;
	logic qword;
	logic zeroExt;
	logic tIn;
	logic outValid;
	logic outReady;
	aluPkg::aluWord result;
	logic tOut;

	logic [63:0] rngState;
	logic [64:0] expected [$];
	logic [64:0] head;
	logic [63:0] stim;
	logic [63:0] opA;
	logic [63:0] opB;
	logic validModel;
	int cycle;
	int accepted;

	`include "aluModel.svh"

	exAlu #(.chunkWidth(aluPkg::chunkWidth)) DUT (
		.clock(clock), .rstN(rstN), .inValid(inValid), .inReady(inReady),
		.rs(rs), .rt(rt), .op(op), .qword(qword), .zeroExt(zeroExt), .tIn(tIn),
		.outValid(outValid), .outReady(outReady), .result(result), .tOut(tOut)
	);

	// 64-bit xorshift
	function automatic logic [63:0] nextRandom();
		logic [63:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 7;
		x ^= x << 17;
		rngState = x;
		return x;
	endfunction

	// corner values now and then for carry and overflow cases
	function automatic logic [63:0] pickOperand();
		logic [63:0] r;
		r = nextRandom();
		case (r[2:0])
			3'd0: return '0;
			3'd1: return '1;
			3'd2: return 64'h8000_0000_0000_0000;
			3'd3: return 64'h0000_0000_8000_0000;
			default: return nextRandom();
		endcase
	endfunction

	task automatic abortRun();
		$display("Checks failed");
		$fatal(1, "run stopped on the first failure");
	endtask

	task automatic checkValue(input logic [63:0] got, input logic [63:0] want,
		input string what);
		if (got !== want) begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, what, got, want);
			abortRun();
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		rngState = 64'd54;
		rstN = 1'b0;
		inValid = 1'b0;
		rs = '0;
		rt = '0;
		op = aluPkg::ADD;
		qword = 1'b0;
		zeroExt = 1'b0;
		tIn = 1'b0;
		outReady = 1'b0;
		validModel = 1'b0;
		cycle = 0;
		accepted = 0;
		repeat (2) @(posedge clock);
		rstN <= 1'b1;
		while (accepted < numOps || expected.size() != 0 || outValid) begin
			@(negedge clock);
		end
		if (DUT.chk.failures != 0) begin
			$display("A handshake assertion failed near the end of the run");
			abortRun();
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

	always @(posedge clock) begin
		if (rstN) begin
			cycle++;
			if (cycle > timeoutCycles) begin
				$display("Timeout after %0d cycles, not every operation came out", cycle);
				abortRun();
			end
		end
	end

	always @(posedge clock) begin
		if (rstN) begin
			if (DUT.chk.failures != 0) begin
				$display("A handshake assertion failed before time %0t", $time);
				abortRun();
			end
			checkValue(outValid, validModel, "outValid");
			if (outValid && outReady) begin
				if (expected.size() == 0) begin
					$display("Output taken at time %0t with no operation pending", $time);
					abortRun();
				end else begin
					head = expected.pop_front();
					checkValue(result, head[63:0], "result");
					checkValue(tOut, head[64], "tOut");
				end
			end
			if (inValid && inReady) begin
				expected.push_back(modelAlu(rs, rt, op, qword, zeroExt, tIn));
				accepted++;
			end
			// valid bit loads when the slot is free or being emptied
			if (!validModel || outReady) begin
				validModel = inValid;
			end
			stim = nextRandom();
			opA = pickOperand();
			opB = (stim[13:11] == 3'd0) ? opA : pickOperand();
			inValid <= (accepted < numOps) && (stim[1:0] != 2'd0);
			outReady <= (accepted >= numOps) || (stim[3:2] != 2'd0);
			rs <= opA;
			rt <= opB;
			op <= aluPkg::aluOp'(stim[7:4]);
			qword <= stim[8];
			zeroExt <= stim[9];
			tIn <= stim[10];
		end
	end

endmodule

// File: aluChk.sv
// handshake assertions for the exAlu output register, bound to exAlu
module aluChk (
	input logic clock,
	input logic rstN,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input aluPkg::aluWord result,
	input logic tOut
);

	// count of failed assertions, read by the testbench
	int failures = 0;

	// nothing valid on the first edge out of reset
	assert property (@(posedge clock) !rstN |=> !outValid)
		else begin
			failures++;
			$error("outValid high right after reset");
		end

	// held output must not move under back-pressure
	assert property (@(posedge clock) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(result) && $stable(tOut))
		else begin
			failures++;
			$error("held output changed before it was taken");
		end

	assert property (@(posedge clock) disable iff (!rstN)
		inReady == (!outValid || outReady))
		else begin
			failures++;
			$error("inReady does not follow outValid and outReady");
		end

endmodule

bind exAlu aluChk chk (
	.clock(clock),
	.rstN(rstN),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.result(result),
	.tOut(tOut)
);

// File: exAlu.sv
// execute-unit ALU top level, adders, compare, result mux and output register
module exAlu #(
	parameter int chunkWidth = aluPkg::chunkWidth
) (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input aluPkg::aluWord rs,
	input aluPkg::aluWord rt,
	input aluPkg::aluOp op,
	input logic qword,
	input logic zeroExt,
	input logic tIn,
	output logic outValid,
	input logic outReady,
	output aluPkg::aluWord result,
	output logic tOut
);

	logic [aluPkg::dataWidth:0] addSum0, addSum1;
	logic [aluPkg::dataWidth:0] subSum0, subSum1;
	logic addLowCarry0, addLowCarry1;
	logic subLowCarry0, subLowCarry1;
	logic cond;
	aluPkg::aluWord nextResult;
	logic nextT;

	carrySelectAdder #(
		.dataWidth(aluPkg::dataWidth), .chunkWidth(chunkWidth), .invertB(1'b0)
	) addAdder (
		.a(rs), .b(rt), .sum0(addSum0), .sum1(addSum1),
		.lowCarry0(addLowCarry0), .lowCarry1(addLowCarry1)
	);

	// rs + ~rt, carry-in one gives rs - rt
	carrySelectAdder #(
		.dataWidth(aluPkg::dataWidth), .chunkWidth(chunkWidth), .invertB(1'b1)
	) subAdder (
		.a(rs), .b(rt), .sum0(subSum0), .sum1(subSum1),
		.lowCarry0(subLowCarry0), .lowCarry1(subLowCarry1)
	);

	compareUnit cmp (
		.rs(rs), .rt(rt), .subSum1(subSum1), .subLowCarry1(subLowCarry1),
		.op(op), .qword(qword), .cond(cond)
	);

	resultSelect sel (
		.rs(rs), .rt(rt),
		.addSum0(addSum0), .addSum1(addSum1), .subSum0(subSum0), .subSum1(subSum1),
		.addLowCarry0(addLowCarry0), .addLowCarry1(addLowCarry1),
		.subLowCarry0(subLowCarry0), .subLowCarry1(subLowCarry1),
		.op(op), .qword(qword), .zeroExt(zeroExt), .tIn(tIn), .cond(cond),
		.nextResult(nextResult), .nextT(nextT)
	);

	aluOutputStage outStage (
		.clock(clock), .rstN(rstN), .inValid(inValid), .outReady(outReady),
		.nextResult(nextResult), .nextT(nextT), .inReady(inReady),
		.outValid(outValid), .result(result), .tOut(tOut)
	);

endmodule

// File: aluOutputStage.sv
// output register with valid/ready handshake
module aluOutputStage (
	input logic clock,
	input logic rstN,
	input logic inValid,
	input logic outReady,
	input aluPkg::aluWord nextResult,
	input logic nextT,
	output logic inReady,
	output logic outValid,
	output aluPkg::aluWord result,
	output logic tOut
);

	logic accept;

	// free slot, or the held result leaves this edge
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	// payload only moves on accept, so it holds under back-pressure
	always_ff @(posedge clock) begin
		if (accept) begin
			result <= nextResult;
			tOut <= nextT;
		end
	end

endmodule

// File: resultSelect.sv
// operation mux, logic ops, carry arithmetic, conditional select and extension
module resultSelect (
	input aluPkg::aluWord rs,
	input aluPkg::aluWord rt,
	input logic [aluPkg::dataWidth:0] addSum0,
	input logic [aluPkg::dataWidth:0] addSum1,
	input logic [aluPkg::dataWidth:0] subSum0,
	input logic [aluPkg::dataWidth:0] subSum1,
	input logic addLowCarry0,
	input logic addLowCarry1,
	input logic subLowCarry0,
	input logic subLowCarry1,
	input aluPkg::aluOp op,
	input logic qword,
	input logic zeroExt,
	input logic tIn,
	input logic cond,
	output aluPkg::aluWord nextResult,
	output logic nextT
);

	localparam int hw = aluPkg::halfWidth;
	localparam int dw = aluPkg::dataWidth;

	logic [dw:0] arithSum;
	logic arithLowCarry;
	logic arithCarry;
	aluPkg::aluWord value;

	// sum and low carry for the arithmetic ops
	always_comb begin
		case (op)
			aluPkg::SUB: begin
				arithSum = subSum1;
				arithLowCarry = subLowCarry1;
			end
			aluPkg::ADC: begin
				arithSum = tIn ? addSum1 : addSum0;
				arithLowCarry = tIn ? addLowCarry1 : addLowCarry0;
			end
			// borrow in means carry-in zero on rs + ~rt
			aluPkg::SBB: begin
				arithSum = tIn ? subSum0 : subSum1;
				arithLowCarry = tIn ? subLowCarry0 : subLowCarry1;
			end
			default: begin
				arithSum = addSum0;
				arithLowCarry = addLowCarry0;
			end
		endcase
	end

	assign arithCarry = qword ? arithSum[dw] : arithLowCarry;

	always_comb begin
		case (op)
			aluPkg::ADD,
			aluPkg::SUB,
			aluPkg::ADC,
			aluPkg::SBB:   value = arithSum[dw-1:0];
			aluPkg::AND:   value = rs & rt;
			aluPkg::OR:    value = rs | rt;
			aluPkg::XOR:   value = rs ^ rt;
			aluPkg::CSELT: value = tIn ? rs : rt;
			// TST, compares and reserved NOR
			default:       value = '0;
		endcase
	end

	always_comb begin
		case (op)
			aluPkg::ADC: nextT = arithCarry;
			aluPkg::SBB: nextT = !arithCarry;
			aluPkg::TST,
			aluPkg::CMPNE,
			aluPkg::CMPHS,
			aluPkg::CMPGE,
			aluPkg::CMPEQ,
			aluPkg::CMPHI,
			aluPkg::CMPGT: nextT = cond;
			default:     nextT = tIn;
		endcase
	end

	// 32-bit results get zero or sign extended
	always_comb begin
		if (qword) begin
			nextResult = value;
		end else if (zeroExt) begin
			nextResult = {{(dw-hw){1'b0}}, value[hw-1:0]};
		end else begin
			nextResult = {{(dw-hw){value[hw-1]}}, value[hw-1:0]};
		end
	end

endmodule

// File: compareUnit.sv
// Z, C, S and V flags, test-zero and compare condition select
module compareUnit (
	input aluPkg::aluWord rs,
	input aluPkg::aluWord rt,
	input logic [aluPkg::dataWidth:0] subSum1,
	input logic subLowCarry1,
	input aluPkg::aluOp op,
	input logic qword,
	output logic cond
);

	localparam int hw = aluPkg::halfWidth;
	localparam int dw = aluPkg::dataWidth;

	logic zLow, zFull;
	logic cLow, cFull;
	logic sLow, sFull;
	logic vLow, vFull;
	logic tstLow, tstFull;

	logic zf, cf, sf, vf, tstZ;

	// flags of rs + ~rt + 1 over the low word
	assign zLow = subSum1[hw-1:0] == '0;
	assign cLow = subLowCarry1;
	assign sLow = subSum1[hw-1];
	assign vLow = (rs[hw-1] ^ rt[hw-1]) & (sLow ^ rs[hw-1]);

	// and over the whole quadword
	assign zFull = zLow && (subSum1[dw-1:hw] == '0);
	assign cFull = subSum1[dw];
	assign sFull = subSum1[dw-1];
	assign vFull = (rs[dw-1] ^ rt[dw-1]) & (sFull ^ rs[dw-1]);

	// no common set bit
	assign tstLow = (rs[hw-1:0] & rt[hw-1:0]) == '0;
	assign tstFull = tstLow && ((rs[dw-1:hw] & rt[dw-1:hw]) == '0);

	assign zf = qword ? zFull : zLow;
	assign cf = qword ? cFull : cLow;
	assign sf = qword ? sFull : sLow;
	assign vf = qword ? vFull : vLow;
	assign tstZ = qword ? tstFull : tstLow;

	always_comb begin
		case (op)
			aluPkg::TST:   cond = tstZ;
			aluPkg::CMPEQ: cond = zf;
			aluPkg::CMPNE: cond = !zf;
			// unsigned, no borrow
			aluPkg::CMPHS: cond = cf;
			aluPkg::CMPHI: cond = cf && !zf;
			// signed, S equals V means rs >= rt
			aluPkg::CMPGE: cond = sf == vf;
			aluPkg::CMPGT: cond = !zf && (sf == vf);
			default:       cond = 1'b0;
		endcase
	end

endmodule

// File: carrySelectAdder.sv
// chunked carry-select adder with sums for whole-word carry-in 0 and 1
module carrySelectAdder #(
	parameter int dataWidth = 64,
	parameter int chunkWidth = 16,
	parameter bit invertB = 1'b0
) (
	input aluPkg::aluWord a,
	input aluPkg::aluWord b,
	output logic [dataWidth:0] sum0,
	output logic [dataWidth:0] sum1,
	output logic lowCarry0,
	output logic lowCarry1
);

	localparam int numChunks = dataWidth / chunkWidth;
	localparam int lowChunks = aluPkg::halfWidth / chunkWidth;

	logic [dataWidth-1:0] bEff;

	// per-chunk sums, one for each chunk carry-in
	logic [chunkWidth:0] part0 [numChunks];
	logic [chunkWidth:0] part1 [numChunks];

	// carry into each chunk, for whole-word carry-in 0 and 1
	logic [numChunks:0] carry0;
	logic [numChunks:0] carry1;

	// subtract instance adds the inverted operand
	assign bEff = invertB ? ~b : b;

	assign carry0[0] = 1'b0;
	assign carry1[0] = 1'b1;

	genvar i;
	generate
		for (i = 0; i < numChunks; i++) begin : chunk
			assign part0[i] = {1'b0, a[i*chunkWidth +: chunkWidth]}
				+ {1'b0, bEff[i*chunkWidth +: chunkWidth]};
			assign part1[i] = {1'b0, a[i*chunkWidth +: chunkWidth]}
				+ {1'b0, bEff[i*chunkWidth +: chunkWidth]} + 1'b1;

			// lower carry picks which precomputed chunk goes through
			assign carry0[i+1] = carry0[i] ? part1[i][chunkWidth] : part0[i][chunkWidth];
			assign carry1[i+1] = carry1[i] ? part1[i][chunkWidth] : part0[i][chunkWidth];

			assign sum0[i*chunkWidth +: chunkWidth] = carry0[i] ?
				part1[i][chunkWidth-1:0] : part0[i][chunkWidth-1:0];
			assign sum1[i*chunkWidth +: chunkWidth] = carry1[i] ?
				part1[i][chunkWidth-1:0] : part0[i][chunkWidth-1:0];
		end
	endgenerate

	assign sum0[dataWidth] = carry0[numChunks];
	assign sum1[dataWidth] = carry1[numChunks];

	// carry out of the low word, for 32-bit operations
	assign lowCarry0 = carry0[lowChunks];
	assign lowCarry1 = carry1[lowChunks];

endmodule

// File: aluPkg.sv
// ALU widths, operation code enum and register word type
package aluPkg;

	// full register width
	localparam int dataWidth = 64;

	// low word used when qword is clear
	localparam int halfWidth = 32;

	// default chunk of the carry-select adders
	localparam int chunkWidth = 16;

	// four-bit ALU operation codes
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		ADC   = 4'd2,
		SBB   = 4'd3,
		TST   = 4'd4,
		AND   = 4'd5,
		OR    = 4'd6,
		XOR   = 4'd7,
		CMPNE = 4'd8,
		CMPHS = 4'd9,
		CMPGE = 4'd10,
		// reserved, gives zero and keeps T
		NOR   = 4'd11,
		CMPEQ = 4'd12,
		CMPHI = 4'd13,
		CMPGT = 4'd14,
		CSELT = 4'd15
	} aluOp;

	// one register operand or result
	typedef logic [dataWidth-1:0] aluWord;

endpackage
